/* hdl/rom_pkg.sv */
/* Video timing, ROM map and width constants shared by the graphics fetch path.
   Imported by every RTL module of the ROM fetch path */
`default_nettype none

package rom_pkg;

    localparam int ROM_AW = 22;             // SDRAM word address
    localparam int ROM_DW = 16;

    typedef logic [8:0]        hpos_t;
    typedef logic [8:0]        vpos_t;
    typedef logic [8:0]        scroll_t;
    typedef logic [ROM_AW-1:0] rom_addr_t;
    typedef logic [ROM_DW-1:0] rom_data_t;

    // Horizontal timing in 6 MHz dots
    localparam hpos_t H_TOTAL   = 9'd384;
    localparam hpos_t H_VISIBLE = 9'd256;
    localparam hpos_t HS_START  = 9'd296;
    localparam hpos_t HS_END    = 9'd328;

    // Vertical timing in lines
    localparam vpos_t V_TOTAL   = 9'd262;
    localparam vpos_t V_VISIBLE = 9'd224;
    localparam vpos_t VS_START  = 9'd232;
    localparam vpos_t VS_END    = 9'd235;

    localparam int NUM_LAYERS = 3;
    localparam int LAYER_W    = $clog2(NUM_LAYERS);
    localparam int LAYER_CHAR = 0;
    localparam int LAYER_SCR1 = 1;
    localparam int LAYER_SCR2 = 2;

    // Each layer owns a 1M word region
    localparam rom_addr_t CHAR_BASE = 22'h00_0000;
    localparam rom_addr_t SCR1_BASE = 22'h10_0000;
    localparam rom_addr_t SCR2_BASE = 22'h20_0000;

endpackage

`default_nettype wire

/* hdl/clk_en_gen.sv */
/* Pixel-rate clock enables derived from the master clock.
   cen12 pulses every other cycle, cen6 one cycle in four */
`timescale 1ns/1ps
`default_nettype none

module clk_en_gen (
    input  wire  clk,
    input  wire  arst_n,
    output logic cen12,
    output logic cen6
);

    logic [1:0] cnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt   <= '0;
            cen12 <= 1'b0;
            cen6  <= 1'b0;
        end else begin
            cnt   <= cnt + 2'd1;
            cen12 <= ~cnt[0];
            cen6  <= (cnt == 2'd3);     // Registered so the enables are glitch free
        end
    end

endmodule

`default_nettype wire

/* hdl/video_timer.sv */
/* Beam counters with registered blanking and sync flags.
   The counters advance on cen6 and the flags are decoded from the next count */
`timescale 1ns/1ps
`default_nettype none

module video_timer import rom_pkg::*; (
    input  wire   clk,
    input  wire   arst_n,
    input  wire   cen6,
    output hpos_t h,
    output vpos_t v,
    output logic  lhbl,
    output logic  lvbl,
    output logic  hs,
    output logic  vs
);

    hpos_t h_nxt;
    vpos_t v_nxt;
    logic  h_wrap;

    always_comb begin
        h_wrap = (h == H_TOTAL - 9'd1);
        h_nxt  = h_wrap ? '0 : h + 9'd1;
        if (h_wrap) begin
            v_nxt = (v == V_TOTAL - 9'd1) ? '0 : v + 9'd1;
        end else begin
            v_nxt = v;
        end
    end

    // Flags use the next count so they move together with h and v
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            h    <= '0;
            v    <= '0;
            lhbl <= 1'b1;       // Beam starts at the top left visible dot
            lvbl <= 1'b1;
            hs   <= 1'b0;
            vs   <= 1'b0;
        end else if (cen6) begin
            h    <= h_nxt;
            v    <= v_nxt;
            lhbl <= (h_nxt < H_VISIBLE);
            lvbl <= (v_nxt < V_VISIBLE);
            hs   <= (h_nxt >= HS_START) && (h_nxt < HS_END);
            vs   <= (v_nxt >= VS_START) && (v_nxt < VS_END);
        end
    end

endmodule

`default_nettype wire

/* hdl/tile_fetch.sv */
/* Tile-row ROM address generation for the char and two scroll layers.
   Addresses reload at each 8-dot tile boundary, one clk after the cen6 event */
`timescale 1ns/1ps
`default_nettype none

module tile_fetch import rom_pkg::*; (
    input  wire                             clk,
    input  wire                             arst_n,
    input  wire                             cen6,
    input  hpos_t                           h,
    input  vpos_t                           v,
    input  wire                             lvbl,
    input  scroll_t                         scr1_h,
    input  scroll_t                         scr2_h,
    input  scroll_t                         scr_v,
    output rom_addr_t [NUM_LAYERS-1:0]      layer_addr,
    output logic      [NUM_LAYERS-1:0]      layer_cs
);

    hpos_t sh1;
    hpos_t sh2;
    vpos_t sv;
    logic  tile_edge;
    logic  addr_vld;

    // Scroll layers share one map layout, 16-line tiles of 8 dots
    function automatic rom_addr_t scr_addr(input rom_addr_t base, input hpos_t hs_pos,
                                           input vpos_t vs_pos);
        return base + rom_addr_t'({vs_pos[8:4], 9'd0}) + rom_addr_t'({hs_pos[8:3], 4'd0})
             + rom_addr_t'(vs_pos[3:0]);
    endfunction

    assign sv  = v + scr_v;     // All wrap modulo 512
    assign sh1 = h + scr1_h;
    assign sh2 = h + scr2_h;

    assign tile_edge = cen6 && (h[2:0] == 3'd0);

    // Tile starting at h is the next one drawn
    always_ff @(posedge clk) begin
        if (tile_edge) begin
            layer_addr[LAYER_CHAR] <= CHAR_BASE + rom_addr_t'({v[8:3], 6'd0})
                                    + rom_addr_t'({h[8:3], 3'd0}) + rom_addr_t'(v[2:0]);
            layer_addr[LAYER_SCR1] <= scr_addr(SCR1_BASE, sh1, sv);
            layer_addr[LAYER_SCR2] <= scr_addr(SCR2_BASE, sh2, sv);
        end
    end

    // Addresses are meaningless until the first boundary after reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            addr_vld <= 1'b0;
        end else if (tile_edge) begin
            addr_vld <= 1'b1;
        end
    end

    assign layer_cs = {NUM_LAYERS{lvbl & addr_vld}};

endmodule

`default_nettype wire

/* hdl/rom_slot.sv */
/* One-word address-tagged ROM cache for a single graphics layer.
   A miss raises a level request that the arbiter ends with a done pulse */
`timescale 1ns/1ps
`default_nettype none

module rom_slot import rom_pkg::*; (
    input  wire       clk,
    input  wire       arst_n,
    input  wire       cs,
    input  rom_addr_t addr,
    output logic      req,
    output rom_addr_t req_addr,
    input  wire       done,
    input  rom_data_t din,
    output rom_data_t dout,
    output logic      data_ok
);

    rom_addr_t tag;
    logic      valid;
    logic      miss;

    // Address is ignored while a fill is pending
    assign miss = cs && !req && (!valid || (addr != tag));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid   <= 1'b0;
            req     <= 1'b0;
            data_ok <= 1'b0;
        end else if (done) begin
            valid   <= 1'b1;
            req     <= 1'b0;
            data_ok <= 1'b1;
        end else if (miss) begin
            req     <= 1'b1;
            data_ok <= 1'b0;    // Held low until the fill lands
        end
    end

    always_ff @(posedge clk) begin
        if (miss) begin
            req_addr <= addr;
        end
        if (done) begin
            tag  <= req_addr;   // Tag follows the word actually fetched
            dout <= din;
        end
    end

endmodule

`default_nettype wire

/* hdl/sdram_arbiter.sv */
/* Round-robin arbiter between the ROM slots and one SDRAM read port.
   Carries one read at a time over a four-phase req/ack handshake */
`timescale 1ns/1ps
`default_nettype none

module sdram_arbiter import rom_pkg::*; (
    input  wire                         clk,
    input  wire                         arst_n,
    input  wire  [NUM_LAYERS-1:0]       slot_req,
    input  rom_addr_t [NUM_LAYERS-1:0]  slot_addr,
    output logic [NUM_LAYERS-1:0]       slot_done,
    output rom_data_t                   slot_data,
    output logic                        sdram_req,
    output rom_addr_t                   sdram_addr,
    input  wire                         sdram_ack,
    input  rom_data_t                   sdram_data
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_HI,
        ST_WAIT_LO,
        ST_DONE
    } arb_state_t;

    arb_state_t         state;
    logic [LAYER_W-1:0] rr_ptr;     // First slot to look at
    logic [LAYER_W-1:0] cur;
    logic [LAYER_W-1:0] pick;
    logic               any_req;

    function automatic logic [LAYER_W-1:0] wrap_idx(input logic [LAYER_W-1:0] base,
                                                    input int off);
        int sum;
        sum = int'(base) + off;
        if (sum >= NUM_LAYERS) begin
            sum = sum - NUM_LAYERS;
        end
        return LAYER_W'(sum);
    endfunction

    // Scan downwards so the slot closest to rr_ptr wins
    always_comb begin
        pick    = rr_ptr;
        any_req = 1'b0;
        for (int k = NUM_LAYERS - 1; k >= 0; k--) begin
            if (slot_req[wrap_idx(rr_ptr, k)]) begin
                pick    = wrap_idx(rr_ptr, k);
                any_req = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_IDLE;
            sdram_req <= 1'b0;
            cur       <= '0;
            rr_ptr    <= '0;
        end else begin
            case (state)
                ST_IDLE: if (any_req) begin
                    sdram_req <= 1'b1;
                    cur       <= pick;
                    state     <= ST_WAIT_HI;
                end
                ST_WAIT_HI: if (sdram_ack) begin
                    sdram_req <= 1'b0;
                    state     <= ST_WAIT_LO;
                end
                ST_WAIT_LO: if (!sdram_ack) state <= ST_DONE;
                ST_DONE: begin
                    rr_ptr <= wrap_idx(cur, 1);
                    state  <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && any_req) begin
            sdram_addr <= slot_addr[pick];  // Stable until the next grant
        end
        if (state == ST_WAIT_HI && sdram_ack) begin
            slot_data <= sdram_data;
        end
    end

    always_comb begin
        slot_done = '0;
        if (state == ST_DONE) begin
            slot_done[cur] = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hdl/game_rom_top.sv */
/* Graphics ROM fetch path of the game core.
   Video timing drives three cached layer slots that share one SDRAM read port */
`timescale 1ns/1ps
`default_nettype none

module game_rom_top import rom_pkg::*; (
    input  wire                         clk,
    input  wire                         arst_n,
    input  scroll_t                     scr1_h,
    input  scroll_t                     scr2_h,
    input  scroll_t                     scr_v,
    output logic                        sdram_req,
    output rom_addr_t                   sdram_addr,
    input  wire                         sdram_ack,
    input  rom_data_t                   sdram_data,
    output logic                        cen6,
    output hpos_t                       h,
    output vpos_t                       v,
    output logic                        lhbl,
    output logic                        lvbl,
    output logic                        hs,
    output logic                        vs,
    output rom_data_t [NUM_LAYERS-1:0]  layer_data,
    output logic      [NUM_LAYERS-1:0]  layer_ok
);

    rom_addr_t [NUM_LAYERS-1:0] layer_addr;
    logic      [NUM_LAYERS-1:0] layer_cs;
    logic      [NUM_LAYERS-1:0] slot_req;
    rom_addr_t [NUM_LAYERS-1:0] slot_addr;
    logic      [NUM_LAYERS-1:0] slot_done;
    rom_data_t                  slot_data;

    clk_en_gen u_cen (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .cen12  (        ),     // Kept for the pixel mixer, not used here
        .cen6   ( cen6   )
    );

    video_timer u_timer (
        .clk    ( clk    ),
        .arst_n ( arst_n ),
        .cen6   ( cen6   ),
        .h      ( h      ),
        .v      ( v      ),
        .lhbl   ( lhbl   ),
        .lvbl   ( lvbl   ),
        .hs     ( hs     ),
        .vs     ( vs     )
    );

    tile_fetch u_fetch (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .cen6       ( cen6       ),
        .h          ( h          ),
        .v          ( v          ),
        .lvbl       ( lvbl       ),
        .scr1_h     ( scr1_h     ),
        .scr2_h     ( scr2_h     ),
        .scr_v      ( scr_v      ),
        .layer_addr ( layer_addr ),
        .layer_cs   ( layer_cs   )
    );

    // One cache slot per layer, index matches LAYER_*
    for (genvar i = 0; i < NUM_LAYERS; i++) begin : g_slot
        rom_slot u_slot (
            .clk      ( clk           ),
            .arst_n   ( arst_n        ),
            .cs       ( layer_cs[i]   ),
            .addr     ( layer_addr[i] ),
            .req      ( slot_req[i]   ),
            .req_addr ( slot_addr[i]  ),
            .done     ( slot_done[i]  ),
            .din      ( slot_data     ),
            .dout     ( layer_data[i] ),
            .data_ok  ( layer_ok[i]   )
        );
    end

    sdram_arbiter u_arb (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .slot_req   ( slot_req   ),
        .slot_addr  ( slot_addr  ),
        .slot_done  ( slot_done  ),
        .slot_data  ( slot_data  ),
        .sdram_req  ( sdram_req  ),
        .sdram_addr ( sdram_addr ),
        .sdram_ack  ( sdram_ack  ),
        .sdram_data ( sdram_data )
    );

endmodule

`default_nettype wire

/* dv/tb_game_rom.sv */
/* Testbench for the graphics ROM fetch path with a random-latency SDRAM model.
   Checks video timing, tile addresses, the SDRAM handshake and the cache fills */
`timescale 1ns/1ps
`default_nettype none

module tb_game_rom import rom_pkg::*; ();

    localparam int NUM_ROWS   = 4;
    localparam int FRAME_DOTS = int'(H_TOTAL) * int'(V_TOTAL);
    localparam int MAX_CYC    = (NUM_ROWS + 1) * (FRAME_DOTS * 4 + 20000); // Lead-in frame too

    // Scroll settings per frame and the hand-worked scroll 1 address of tile (0,0)
    localparam scroll_t   ROW_SCR1_H [NUM_ROWS] = '{9'd0, 9'd13, 9'd300, 9'd511};
    localparam scroll_t   ROW_SCR2_H [NUM_ROWS] = '{9'd0, 9'd100, 9'd7, 9'd256};
    localparam scroll_t   ROW_SCR_V  [NUM_ROWS] = '{9'd0, 9'd5, 9'd40, 9'd500};
    localparam rom_addr_t ROW_TILE0  [NUM_ROWS] = '{22'h10_0000, 22'h10_0015,
                                                     22'h10_0658, 22'h10_41F4};

    logic                       clk = 1'b0;
    logic                       arst_n;
    scroll_t                    scr1_h;
    scroll_t                    scr2_h;
    scroll_t                    scr_v;
    logic                       sdram_req;
    rom_addr_t                  sdram_addr;
    logic                       sdram_ack;
    rom_data_t                  sdram_data;
    logic                       cen6;
    hpos_t                      h;
    vpos_t                      v;
    logic                       lhbl;
    logic                       lvbl;
    logic                       hs;
    logic                       vs;
    rom_data_t [NUM_LAYERS-1:0] layer_data;
    logic      [NUM_LAYERS-1:0] layer_ok;

    int                    cyc_cnt = 0;
    int                    err_cnt = 0;
    int                    cur_row = 0;
    int                    tile0_hits = 0;
    int                    fill_cnt = 0;
    int                    hs_cnt = 0;
    int                    dot_cnt = 0;
    logic                  frame_vld = 1'b0;
    logic                  hs_q, vs_q, req_q, ack_q;
    rom_addr_t             addr_q;
    logic [NUM_LAYERS-1:0] ok_q;
    logic [NUM_LAYERS-1:0] req_seen = '0;
    rom_addr_t             last_req [NUM_LAYERS];
    rom_addr_t             exp_cur  [NUM_LAYERS];      // Most recent tile boundary
    rom_addr_t             exp_prev [NUM_LAYERS];      // The one before
    hpos_t                 cur_h, prev_h;
    vpos_t                 cur_v, prev_v;
    logic                  cur_vld = 1'b0;
    logic                  prev_vld = 1'b0;
    int                    cur_char = 0;
    int                    prev_char = 0;

    game_rom_top game_rom_top_inst (
        .clk(clk), .arst_n(arst_n), .scr1_h(scr1_h), .scr2_h(scr2_h), .scr_v(scr_v),
        .sdram_req(sdram_req), .sdram_addr(sdram_addr), .sdram_ack(sdram_ack),
        .sdram_data(sdram_data), .cen6(cen6), .h(h), .v(v), .lhbl(lhbl), .lvbl(lvbl),
        .hs(hs), .vs(vs), .layer_data(layer_data), .layer_ok(layer_ok)
    );

    always #5 clk = ~clk;

    function automatic rom_data_t model_word(input rom_addr_t a);
        return a[15:0] ^ 16'hA5C3;
    endfunction

    // Tile-row address of the tile starting at dot x of line y
    function automatic rom_addr_t tile_addr(input int layer, input int x, input int y,
                                            input int sx, input int sy);
        int hh;
        int vv;
        if (layer == LAYER_CHAR) begin
            return CHAR_BASE + rom_addr_t'((y / 8) * 64 + (x / 8) * 8 + y % 8);
        end
        hh = (x + sx) % 512;
        vv = (y + sy) % 512;
        return ((layer == LAYER_SCR1) ? SCR1_BASE : SCR2_BASE)
             + rom_addr_t'((vv / 16) * 512 + (hh / 8) * 16 + vv % 16);
    endfunction

    function automatic int addr_layer(input rom_addr_t a);
        if (a < SCR1_BASE) return LAYER_CHAR;
        if (a < SCR2_BASE) return LAYER_SCR1;
        if (int'(a) < 2 * int'(SCR2_BASE) - int'(SCR1_BASE)) return LAYER_SCR2;
        return -1;
    endfunction

    task automatic stop_on_error(input string what);
        err_cnt++;
        $display("%s", what);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic compare_pos(input string name, input hpos_t got, input hpos_t exp);
        if (got !== exp) stop_on_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic compare_addr(input string name, input rom_addr_t got, input rom_addr_t exp);
        if (got !== exp) stop_on_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic compare_data(input string name, input rom_data_t got, input rom_data_t exp);
        if (got !== exp) stop_on_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) stop_on_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        if (got != exp) stop_on_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_request();
        int    lyr;
        hpos_t bh;
        vpos_t bv;
        lyr = addr_layer(sdram_addr);
        if (lyr < 0) stop_on_error($sformatf("SDRAM read at %h is outside every layer", sdram_addr));
        if (req_seen[lyr] && sdram_addr == last_req[lyr]) begin
            stop_on_error($sformatf("layer %0d read %h twice in a row", lyr, sdram_addr));
        end
        if (cur_vld && sdram_addr == exp_cur[lyr]) begin
            bh = cur_h;
            bv = cur_v;
            if (lyr == LAYER_CHAR) cur_char++;
        end else if (prev_vld && sdram_addr == exp_prev[lyr]) begin
            bh = prev_h;
            bv = prev_v;
            if (lyr == LAYER_CHAR) prev_char++;
        end else begin
            stop_on_error($sformatf("mismatch sdram_addr: got %h expected %h or %h",
                                    sdram_addr, exp_cur[lyr], exp_prev[lyr]));
        end
        if (lyr == LAYER_SCR1 && bh == '0 && bv == '0) begin
            compare_addr("sdram_addr", sdram_addr, ROW_TILE0[cur_row]);
            tile0_hits++;
        end
        last_req[lyr] = sdram_addr;
        req_seen[lyr] = 1'b1;
    endtask

    // Char layer ignores scroll, so every visible tile gets exactly one read
    task automatic record_boundary();
        if (prev_vld && prev_v < V_VISIBLE) compare_count("char reads per tile", prev_char, 1);
        prev_vld  = cur_vld;
        prev_h    = cur_h;
        prev_v    = cur_v;
        prev_char = cur_char;
        exp_prev  = exp_cur;
        cur_vld   = 1'b1;
        cur_h     = h;
        cur_v     = v;
        cur_char  = 0;
        exp_cur[LAYER_CHAR] = tile_addr(LAYER_CHAR, int'(h), int'(v), 0, 0);
        exp_cur[LAYER_SCR1] = tile_addr(LAYER_SCR1, int'(h), int'(v), int'(scr1_h), int'(scr_v));
        exp_cur[LAYER_SCR2] = tile_addr(LAYER_SCR2, int'(h), int'(v), int'(scr2_h), int'(scr_v));
    endtask

    // SDRAM read port, 1 to 6 cycles to ack
    initial begin
        int   lat;
        logic pending;
        sdram_ack  = 1'b0;
        sdram_data = '0;
        pending    = 1'b0;
        lat        = 0;
        void'($urandom(11567));
        forever begin
            @(posedge clk);
            #1;
            if (!arst_n) begin
                sdram_ack = 1'b0;
                pending   = 1'b0;
            end else if (sdram_ack) begin
                if (!sdram_req) sdram_ack = 1'b0;
            end else if (sdram_req) begin
                if (!pending) begin
                    pending = 1'b1;
                    lat     = $urandom_range(6, 1);
                end
                lat = lat - 1;
                if (lat == 0) begin
                    sdram_ack  = 1'b1;
                    sdram_data = model_word(sdram_addr);
                    pending    = 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= MAX_CYC) begin
            $display("Timeout after %0d cycles without reaching the end of the frames", cyc_cnt);
            $display("Verification failed");
            $fatal(1);
        end
    end

    // Video timing
    always @(negedge clk) begin
        if (arst_n) begin
            compare_bit("lhbl", lhbl, h < H_VISIBLE);
            compare_bit("lvbl", lvbl, v < V_VISIBLE);
            if (hs && !hs_q) hs_cnt++;
            if (vs && !vs_q) begin
                if (frame_vld) begin
                    compare_count("hs pulses per frame", hs_cnt, int'(V_TOTAL));
                    compare_count("dots per frame", dot_cnt, FRAME_DOTS);
                end
                hs_cnt    = 0;
                dot_cnt   = 0;
                frame_vld = 1'b1;
            end else if (cen6) begin
                dot_cnt++;
            end
        end
        hs_q = hs;
        vs_q = vs;
    end

    // Fills first, then the port, then the boundary that the next reads will use
    always @(negedge clk) begin
        if (arst_n) begin
            for (int i = 0; i < NUM_LAYERS; i++) begin
                if (layer_ok[i] && !ok_q[i]) begin
                    compare_data($sformatf("layer_data[%0d]", i), layer_data[i],
                                 model_word(last_req[i]));
                    fill_cnt++;
                end
            end
            if (req_q && !sdram_req && !ack_q) stop_on_error("SDRAM req dropped before ack");
            if (req_q && sdram_req) compare_addr("sdram_addr", sdram_addr, addr_q);
            if (!req_q && sdram_req) begin
                if (ack_q) stop_on_error("new SDRAM req started while ack was still high");
                check_request();
            end
            if (cen6 && h[2:0] == 3'd0) record_boundary();
        end
        ok_q   = layer_ok;
        req_q  = sdram_req;
        ack_q  = sdram_ack;
        addr_q = sdram_addr;
    end

    initial begin
        arst_n = 1'b0;
        scr1_h = ROW_SCR1_H[0];
        scr2_h = ROW_SCR2_H[0];
        scr_v  = ROW_SCR_V[0];
        repeat (7) @(posedge clk);
        @(negedge clk);
        compare_bit("sdram_req", sdram_req, 1'b0);
        compare_bit("hs", hs, 1'b0);
        compare_bit("vs", vs, 1'b0);
        compare_pos("h", h, '0);
        compare_pos("v", v, '0);
        for (int i = 0; i < NUM_LAYERS; i++) begin
            compare_bit($sformatf("layer_ok[%0d]", i), layer_ok[i], 1'b0);
        end
        @(posedge clk);
        #1 arst_n = 1'b1;
        @(posedge vs);
        #1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            cur_row = r;
            scr1_h  = ROW_SCR1_H[r];
            scr2_h  = ROW_SCR2_H[r];
            scr_v   = ROW_SCR_V[r];
            @(posedge vs);      // One full frame per row
            #1;
        end
        if (tile0_hits < NUM_ROWS) stop_on_error("scroll 1 missed the first tile of a frame");
        if (fill_cnt == 0) stop_on_error("no layer ever completed a fill");
        if (err_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
hdl/rom_pkg.sv
hdl/clk_en_gen.sv
hdl/video_timer.sv
hdl/tile_fetch.sv
hdl/rom_slot.sv
hdl/sdram_arbiter.sv
hdl/game_rom_top.sv
dv/tb_game_rom.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log for the fail message
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

if ! verilator --binary --timing --timescale 1ns/1ps --top-module tb_game_rom \
        -Mdir "$OBJ" -f sources.f; then
    echo "Build failed"
    exit 1
fi

"./$OBJ/Vtb_game_rom" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Verification failed" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ "$run_status" -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
echo "Simulation finished without failures"
exit 0
